// ==== vlog.f ====
logic/err_trk_pkg.sv
logic/frame_sram.sv
logic/error_tracker_core.sv
logic/tracker_wb_regs.sv
logic/error_tracker_top.sv
verification/tracker_props.sv
verification/tracker_checker.sv
verification/tb_error_tracker.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in its output
verilator --binary --timing --assert -j 0 --top-module tb_error_tracker -f vlog.f -Mdir obj_dir \
	|| { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/Vtb_error_tracker +verilator+error+limit+100)"
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== verification/tb_error_tracker.sv ====
module tb_error_tracker
	import err_trk_pkg::*;
();

	localparam int addr_width = 6;
	localparam int depth = 2 ** addr_width;

	logic clk;
	logic rstb;
	logic trigger;
	logic [lane_count*err_bits-1:0] errors;
	logic [lane_count-1:0] prbs_flags;
	logic [lane_count-1:0] bitstream;
	logic [2*lane_count-1:0] sd_flags;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [2:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic [31:0] rng_state;
	logic [31:0] rd;
	int tb_errors;
	int timeouts;
	int chk_errors;
	int chk_reads;

	error_tracker_top #(.addr_width(addr_width)) i_error_tracker_top (.*);

	tracker_checker #(.addr_width(addr_width)) i_tracker_checker (
		.clk(clk), .rstb(rstb), .trigger(trigger), .errors(errors),
		.prbs_flags(prbs_flags), .bitstream(bitstream), .sd_flags(sd_flags),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.error_count(chk_errors), .read_count(chk_reads)
	);

	bind error_tracker_core tracker_props #(.addr_width(addr_width)) i_tracker_props (
		.clk(clk), .rstb(rstb), .state(state), .grp_cnt(grp_cnt), .wr_ptr(wr_ptr),
		.done(done), .rearm(rearm), .mem_we_n(mem_we_n)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50;
			clk = ~clk;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic randomize_inputs();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		for (int i = 0; i < lane_count*err_bits/32; i++) begin
			errors[i*32 +: 32] = next_rand();
		end
		a = next_rand();
		b = next_rand();
		c = next_rand();
		prbs_flags = {a[15:0], b};
		bitstream = {a[31:16], c};
		sd_flags = {next_rand(), next_rand(), next_rand()};
	endtask

	task automatic finish_run();
		int prop_fails;
		prop_fails = i_error_tracker_top.i_error_tracker_core.i_tracker_props.failures;
		$write("Checker errors %0d, reads checked %0d, testbench errors %0d, ",
			chk_errors, chk_reads, tb_errors);
		$display("timeouts %0d, assertion failures %0d", timeouts, prop_fails);
		if (chk_errors == 0 && tb_errors == 0 && timeouts == 0 &&
			prop_fails == 0 && chk_reads > 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	task automatic wait_ack(input string what);
		int cycles;
		cycles = 0;
		while (!wb_ack && cycles < 20) begin
			@(posedge clk);
			#10;
			cycles++;
		end
		if (!wb_ack) begin
			$display("Timeout: no Wishbone ack for a %s at time %0t", what, $time);
			timeouts++;
		end
	endtask

	task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
		@(posedge clk);
		#10;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		wait_ack("write");
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic bus_read(input logic [2:0] adr, output logic [31:0] data);
		@(posedge clk);
		#10;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_adr = adr;
		wait_ack("read");
		data = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			tb_errors++;
			$display("ERR %0t wb_dat_r %s: expected %h, actual %h", $time, name, exp, got);
		end
	endtask

	task automatic expect_status(input int ptr, input logic done_bit);
		logic [31:0] exp;
		logic [31:0] got;
		exp = 32'(ptr);
		exp[31] = done_bit;
		bus_read(reg_status, got);
		check_word("status", exp, got);
	endtask

	// Single-cycle trigger, then enough idle cycles for the group to finish
	task automatic capture_once();
		@(posedge clk);
		#10;
		trigger = 1'b1;
		@(posedge clk);
		#10;
		trigger = 1'b0;
		repeat (8) @(posedge clk);
	endtask

	task automatic read_frames(input int count);
		logic [31:0] d;
		for (int a = 0; a < count; a++) begin
			bus_write(reg_frame_addr, 32'(a));
			for (int w = 0; w < chunk_count; w++) begin
				bus_read(reg_data_first + 3'(w), d);
			end
			check_word("window 4 upper bits", 32'hffff_0000, d & 32'hffff_0000);
		end
	endtask

	initial begin
		forever begin
			@(posedge clk);
			#10;
			randomize_inputs();
		end
	end

	initial begin
		rng_state = 32'h87272ad1;
		rstb = 1'b0;
		trigger = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		randomize_inputs();
		repeat (16) @(posedge clk);
		#10;
		rstb = 1'b1;

		// Idle state and the frame address register
		expect_status(0, 1'b0);
		bus_read(reg_frame_addr, rd);
		check_word("frame address", 32'h0, rd);
		bus_write(reg_frame_addr, 32'h0000_002a);
		bus_read(reg_frame_addr, rd);
		check_word("frame address", 32'h0000_002a, rd);

		// Random captures stopped by a read request
		repeat (5) capture_once();
		bus_write(reg_control, 32'h2);
		expect_status(20, 1'b1);
		read_frames(20);

		// Rearm, then control writes without the read request bit
		bus_write(reg_control, 32'h1);
		expect_status(0, 1'b0);
		repeat (2) capture_once();
		bus_write(reg_control, 32'hffff_fffd);
		bus_write(reg_control, 32'h0);
		expect_status(8, 1'b0);

		// Fill the memory; later triggers must not touch it
		repeat (14) capture_once();
		expect_status(depth - 1, 1'b1);
		repeat (3) capture_once();
		expect_status(depth - 1, 1'b1);
		read_frames(depth);

		// Fresh capture after rearm lands at address 0
		bus_write(reg_control, 32'h1);
		expect_status(0, 1'b0);
		capture_once();
		bus_write(reg_control, 32'h2);
		expect_status(4, 1'b1);
		read_frames(4);
		finish_run();
	end

endmodule

// ==== verification/tracker_checker.sv ====
module tracker_checker
	import err_trk_pkg::*;
#(
	parameter int addr_width = 12
) (
	input  logic                           clk,
	input  logic                           rstb,
	input  logic                           trigger,
	input  logic [lane_count*err_bits-1:0] errors,
	input  logic [lane_count-1:0]          prbs_flags,
	input  logic [lane_count-1:0]          bitstream,
	input  logic [2*lane_count-1:0]        sd_flags,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [2:0]                     wb_adr,
	input  logic [31:0]                    wb_dat_w,
	input  logic [31:0]                    wb_dat_r,
	input  logic                           wb_ack,
	output int                             error_count,
	output int                             read_count
);

	localparam logic [addr_width-1:0] last_addr = '1;

	// Model of the frame memory and of the capture state
	err_frame_u model_mem [2**addr_width];
	logic [addr_width-1:0] model_ptr;
	logic [addr_width-1:0] model_frame_addr;
	logic model_done;
	logic [31:0] exp_word;
	logic [2:0] exp_adr;
	logic exp_pending;
	logic exp_valid;
	logic [frame_bits-1:0] flat;

	// Frames 0 to 2 hold 16 error lanes each, frame 3 the flags
	function automatic err_frame_u snapshot_frame(input int f);
		err_frame_u fr;
		fr = '0;
		if (f < 3) begin
			fr.errors.lanes = errors[f*lanes_per_frame*err_bits +: lanes_per_frame*err_bits];
		end else begin
			fr.flags.sd = sd_flags[2*sd_first_lane +: 2*sd_lanes];
			fr.flags.bitstream = bitstream;
			fr.flags.prbs = prbs_flags;
		end
		return fr;
	endfunction

	// Inputs at the falling edge are what the next rising edge samples
	always @(negedge clk) begin
		if (!rstb) begin
			model_ptr = '0;
			model_frame_addr = '0;
			model_done = 1'b0;
			exp_pending = 1'b0;
		end else begin
			if (wb_ack && exp_pending) begin
				exp_pending = 1'b0;
				if (exp_valid) begin
					read_count++;
					if (wb_dat_r !== exp_word) begin
						error_count++;
						$display("ERR %0t wb_dat_r at offset %0d: expected %h, actual %h",
							$time, exp_adr, exp_word, wb_dat_r);
					end
				end
			end
			if (wb_cyc && wb_stb && !wb_ack && !wb_we) begin
				// Expected word reflects the state before the edge that sees the request
				exp_pending = 1'b1;
				exp_adr = wb_adr;
				exp_word = '0;
				flat = model_mem[model_frame_addr];
				case (wb_adr)
					reg_control: exp_word = '0;
					reg_status: begin
						exp_word[addr_width-1:0] = model_ptr;
						exp_word[31] = model_done;
					end
					reg_frame_addr: exp_word[addr_width-1:0] = model_frame_addr;
					3'd7: exp_word = {16'hffff, flat[frame_bits-1 -: 16]};
					default: exp_word = flat[(int'(wb_adr) - int'(reg_data_first))*32 +: 32];
				endcase
				// Memory words only mean something once capture has stopped
				exp_valid = (wb_adr < reg_data_first) || model_done;
			end
			if (wb_cyc && wb_stb && !wb_ack && wb_we) begin
				if (wb_adr == reg_frame_addr) begin
					model_frame_addr = wb_dat_w[addr_width-1:0];
				end
				if (wb_adr == reg_control) begin
					if (wb_dat_w[0] && model_done) begin
						model_ptr = '0;
						model_done = 1'b0;
					end else if (wb_dat_w[1]) begin
						model_done = 1'b1;
					end
				end
			end
			// One trigger stores four frames, stopping at the last word
			if (trigger && !model_done) begin
				for (int f = 0; f < 4; f++) begin
					if (!model_done) begin
						model_mem[model_ptr] = snapshot_frame(f);
						if (model_ptr == last_addr) begin
							model_done = 1'b1;
						end else begin
							model_ptr = model_ptr + 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

// ==== verification/tracker_props.sv ====
module tracker_props #(
	parameter int addr_width = 12
) (
	input logic                  clk,
	input logic                  rstb,
	input logic [1:0]            state,
	input logic [1:0]            grp_cnt,
	input logic [addr_width-1:0] wr_ptr,
	input logic                  done,
	input logic                  rearm,
	input logic                  mem_we_n
);

	// Encoding of the core FSM's store state
	localparam logic [1:0] store_state = 2'd1;

	int failures;

	we_in_store: assert property (@(posedge clk) disable iff (!rstb)
		!mem_we_n |-> state == store_state)
	else begin
		failures++;
		$error("memory write enable low outside the store state");
	end

	// Host readback must see a frozen pointer
	ptr_frozen: assert property (@(posedge clk) disable iff (!rstb)
		(done && !rearm) |=> $stable(wr_ptr))
	else begin
		failures++;
		$error("write pointer moved while done without rearm");
	end

	// Four writes per group bring the counter back to 0 as the group ends
	grp_in_store: assert property (@(posedge clk) disable iff (!rstb)
		(grp_cnt != 2'd0) |-> (state == store_state))
	else begin
		failures++;
		$error("group counter nonzero outside the store state");
	end

endmodule

// ==== logic/error_tracker_top.sv ====
module error_tracker_top
	import err_trk_pkg::*;
#(
	parameter int addr_width = 12
) (
	input  logic                           clk,
	input  logic                           rstb,
	input  logic                           trigger,
	input  logic [lane_count*err_bits-1:0] errors,
	input  logic [lane_count-1:0]          prbs_flags,
	input  logic [lane_count-1:0]          bitstream,
	input  logic [2*lane_count-1:0]        sd_flags,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [2:0]                     wb_adr,
	input  logic [31:0]                    wb_dat_w,
	output logic [31:0]                    wb_dat_r,
	output logic                           wb_ack
);

	logic [addr_width-1:0] wr_ptr;
	logic done;
	logic read_req;
	logic rearm;
	logic [addr_width-1:0] rd_addr;

	// Memory port
	logic mem_we_n;
	logic [addr_width-1:0] mem_addr;
	err_frame_u mem_wdata;
	err_frame_u mem_rdata;

	error_tracker_core #(
		.addr_width(addr_width)
	) i_error_tracker_core (
		.clk(clk),
		.rstb(rstb),
		.trigger(trigger),
		.errors(errors),
		.prbs_flags(prbs_flags),
		.bitstream(bitstream),
		.sd_flags(sd_flags),
		.read_req(read_req),
		.rearm(rearm),
		.rd_addr(rd_addr),
		.wr_ptr(wr_ptr),
		.done(done),
		.mem_we_n(mem_we_n),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	frame_sram #(
		.addr_width(addr_width)
	) i_frame_sram (
		.clk(clk),
		.we_n(mem_we_n),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

	tracker_wb_regs #(
		.addr_width(addr_width)
	) i_tracker_wb_regs (
		.clk(clk),
		.rstb(rstb),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wr_ptr(wr_ptr),
		.done(done),
		.rd_frame(mem_rdata),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.read_req(read_req),
		.rearm(rearm),
		.rd_addr(rd_addr)
	);

endmodule

// ==== logic/tracker_wb_regs.sv ====
module tracker_wb_regs
	import err_trk_pkg::*;
#(
	parameter int addr_width = 12
) (
	input  logic                  clk,
	input  logic                  rstb,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [2:0]            wb_adr,
	input  logic [31:0]           wb_dat_w,
	input  logic [addr_width-1:0] wr_ptr,
	input  logic                  done,
	input  err_frame_u            rd_frame,
	output logic [31:0]           wb_dat_r,
	output logic                  wb_ack,
	output logic                  read_req,
	output logic                  rearm,
	output logic [addr_width-1:0] rd_addr
);

	logic req;
	logic wr_req;
	logic [2:0] win;
	logic [frame_bits-1:0] frame_flat;
	logic [31:0] rd_word;

	// New cycle seen while ack is low; ack follows on the next edge
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign wr_req = req && wb_we;

	// Data window index, 0 to 4 for offsets 3 to 7
	assign win = wb_adr - reg_data_first;
	assign frame_flat = rd_frame;

	// Read decode
	always_comb begin
		rd_word = '0;
		case (wb_adr)
			reg_control: begin
				// Command bits are pulses and read as zero
				rd_word = '0;
			end
			reg_status: begin
				rd_word[addr_width-1:0] = wr_ptr;
				rd_word[31] = done;
			end
			reg_frame_addr: begin
				rd_word[addr_width-1:0] = rd_addr;
			end
			default: begin
				if (win < 3'(chunk_count - 1)) begin
					rd_word = frame_flat[win*32 +: 32];
				end else begin
					// Top window is only half used, marked with ones
					rd_word = {16'hffff, frame_flat[frame_bits-1 -: 16]};
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			wb_ack <= 1'b0;
			read_req <= 1'b0;
			rearm <= 1'b0;
			rd_addr <= '0;
		end else begin
			wb_ack <= req;
			// Control bits give single-cycle strobes to the core
			read_req <= wr_req && (wb_adr == reg_control) && wb_dat_w[1];
			rearm <= wr_req && (wb_adr == reg_control) && wb_dat_w[0];
			if (wr_req && (wb_adr == reg_frame_addr)) begin
				rd_addr <= wb_dat_w[addr_width-1:0];
			end
		end
	end

	// Read data lines up with ack
	always_ff @(posedge clk) begin
		if (req) begin
			wb_dat_r <= rd_word;
		end
	end

endmodule

// ==== logic/error_tracker_core.sv ====
module error_tracker_core
	import err_trk_pkg::*;
#(
	parameter int addr_width = 12
) (
	input  logic                           clk,
	input  logic                           rstb,
	input  logic                           trigger,
	input  logic [lane_count*err_bits-1:0] errors,
	input  logic [lane_count-1:0]          prbs_flags,
	input  logic [lane_count-1:0]          bitstream,
	input  logic [2*lane_count-1:0]        sd_flags,
	input  logic                           read_req,
	input  logic                           rearm,
	input  logic [addr_width-1:0]          rd_addr,
	output logic [addr_width-1:0]          wr_ptr,
	output logic                           done,
	output logic                           mem_we_n,
	output logic [addr_width-1:0]          mem_addr,
	output err_frame_u                     mem_wdata
);

	localparam int err_frames = lane_count / lanes_per_frame;
	localparam logic [addr_width-1:0] max_addr = '1;

	localparam logic [1:0] st_ready = 2'd0;
	localparam logic [1:0] st_store = 2'd1;
	localparam logic [1:0] st_done = 2'd2;

	logic [1:0] state;
	logic [1:0] grp_cnt;
	logic rd_pend;
	logic at_end;
	logic grp_last;
	logic chain;
	logic load_snap;

	err_frame_u snap_next [4];
	err_frame_u snap [4];

	// Pack the live inputs into the four frames of one snapshot
	always_comb begin
		for (int f = 0; f < err_frames; f++) begin
			snap_next[f].errors.pad = '0;
			for (int l = 0; l < lanes_per_frame; l++) begin
				snap_next[f].errors.lanes[l] =
					errors[(f*lanes_per_frame + l)*err_bits +: err_bits];
			end
		end
		snap_next[err_frames].flags.sd = sd_flags[2*sd_first_lane +: 2*sd_lanes];
		snap_next[err_frames].flags.bitstream = bitstream;
		snap_next[err_frames].flags.prbs = prbs_flags;
	end

	assign at_end = (wr_ptr == max_addr);
	assign grp_last = (grp_cnt == 2'd3);

	// Trigger on the last write of a group starts the next group at once,
	// unless a read request is waiting
	assign chain = grp_last && trigger && !rd_pend && !read_req;

	// Track the inputs while idle; take a fresh copy when groups chain
	assign load_snap = (state == st_ready) ||
		((state == st_store) && !at_end && chain);

	always_ff @(posedge clk) begin
		if (load_snap) begin
			snap <= snap_next;
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= st_ready;
			grp_cnt <= '0;
			wr_ptr <= '0;
			mem_we_n <= 1'b1;
			rd_pend <= 1'b0;
		end else begin
			case (state)
				st_ready: begin
					grp_cnt <= '0;
					if (trigger) begin
						state <= st_store;
						mem_we_n <= 1'b0;
						// Read request alongside the trigger waits for the group
						rd_pend <= read_req;
					end else if (read_req) begin
						state <= st_done;
					end
				end
				st_store: begin
					if (at_end) begin
						// Last word of memory just written, pointer stays put
						state <= st_done;
						mem_we_n <= 1'b1;
						grp_cnt <= '0;
						rd_pend <= 1'b0;
					end else begin
						wr_ptr <= wr_ptr + 1'b1;
						// Wraps back to 0 after the flag frame
						grp_cnt <= grp_cnt + 2'd1;
						if (grp_last) begin
							if (!chain) begin
								mem_we_n <= 1'b1;
								rd_pend <= 1'b0;
								if (rd_pend || read_req) begin
									state <= st_done;
								end else begin
									state <= st_ready;
								end
							end
						end else begin
							rd_pend <= rd_pend | read_req;
						end
					end
				end
				st_done: begin
					mem_we_n <= 1'b1;
					if (rearm) begin
						state <= st_ready;
						wr_ptr <= '0;
						grp_cnt <= '0;
					end
				end
				default: begin
					state <= st_ready;
					mem_we_n <= 1'b1;
					grp_cnt <= '0;
					rd_pend <= 1'b0;
				end
			endcase
		end
	end

	assign done = (state == st_done);

	// Host owns the memory address once capture has stopped
	assign mem_addr = done ? rd_addr : wr_ptr;
	assign mem_wdata = snap[grp_cnt];

endmodule

// ==== logic/frame_sram.sv ====
module frame_sram
	import err_trk_pkg::*;
#(
	parameter int addr_width = 12
) (
	input  logic                  clk,
	input  logic                  we_n,
	input  logic [addr_width-1:0] addr,
	input  err_frame_u            wdata,
	output err_frame_u            rdata
);

	// Behavioral model of a single-port macro
	localparam int depth = 2 ** addr_width;

	err_frame_u mem [depth];

	// Write port, active low enable like the macro
	always_ff @(posedge clk) begin
		if (!we_n) begin
			mem[addr] <= wdata;
		end
	end

	// Registered read every cycle
	// A write to the same address returns the old word
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

// ==== logic/err_trk_pkg.sv ====
package err_trk_pkg;

	// Receiver geometry, fixed because the frame layout depends on it
	localparam int lane_count = 48;
	localparam int err_bits = 8;
	localparam int lanes_per_frame = 16;

	// Only part of the sliding detector lanes fit in the flag frame
	localparam int sd_first_lane = 8;
	localparam int sd_lanes = 24;

	localparam int frame_bits = 144;

	// 32-bit host windows needed to cover one frame
	localparam int chunk_count = 5;

	// Register map, word offsets on the Wishbone bus
	localparam logic [2:0] reg_control = 3'd0;
	localparam logic [2:0] reg_status = 3'd1;
	localparam logic [2:0] reg_frame_addr = 3'd2;
	localparam logic [2:0] reg_data_first = 3'd3;

	// One memory word, either an error frame or the flag frame of a snapshot
	typedef union packed {
		struct packed {
			logic [15:0] pad;
			// Lane 0 of the frame sits in the low byte
			logic [lanes_per_frame-1:0][err_bits-1:0] lanes;
		} errors;
		struct packed {
			// Two bits per detector lane, lane sd_first_lane lowest
			logic [2*sd_lanes-1:0] sd;
			logic [lane_count-1:0] bitstream;
			logic [lane_count-1:0] prbs;
		} flags;
	} err_frame_u;

endpackage
